/* common/cart_pkg.sv */
// ----------------------------------------------------------
// Shared types for the MSX cartridge VDP port subsystem
// Referenced by scoped name from every design stage
// ----------------------------------------------------------
package cart_pkg;

	// ----------------------------------------------------------
	// Constants
	// ----------------------------------------------------------
	parameter int VRAM_ADDR_W_DEF = 14;		// Default VRAM address width, 16 KB

	// Host I/O port codes on ta
	parameter logic [1:0] PORT_VRAM_DATA = 2'd0;	// VRAM data port
	parameter logic [1:0] PORT_VDP_CTRL  = 2'd1;	// Control / address port

	// Address field is sized for the widest supported memory
	// Narrower builds use only the low VRAM_ADDR_W bits
	typedef logic [VRAM_ADDR_W_DEF-1:0] vram_addr_t;

	// ----------------------------------------------------------
	// Host bus command, one per completed strobe
	// ----------------------------------------------------------
	typedef struct packed {
		logic		valid;			// Single cycle pulse
		logic		is_write;		// 1 = OUT, 0 = IN
		logic [1:0]	port;			// Port code from ta
		logic [7:0]	wdata;			// Byte captured from td
	} bus_cmd_t;

	// ----------------------------------------------------------
	// Video memory request and response
	// ----------------------------------------------------------
	typedef struct packed {
		logic		is_write;		// 1 = store, 0 = prefetch read
		vram_addr_t	address;		// Byte address
		logic [7:0]	wdata;			// Store data
	} vram_req_t;

	typedef struct packed {
		logic		valid;			// Read data strobe
		logic [7:0]	rdata;			// Read byte
	} vram_rsp_t;

endpackage

/* design/msxbus/msx_bus_sync.sv */
// ----------------------------------------------------------
// Brings the asynchronous MSX I/O strobes into the clk domain
// and turns each host access into one bus command pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module msx_bus_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic				clk,
	input  logic				w_n_reset,
	// Host side
	input  logic				n_ce,
	input  logic				n_trd,
	input  logic				n_twr,
	input  logic [1:0]			ta,
	input  logic [7:0]			td_in,
	output logic [7:0]			td_out,
	output logic				tdir,		// High while the cartridge drives td
	// Decoder side
	input  logic [7:0]			read_data,
	output cart_pkg::bus_cmd_t	bus_cmd
);

	// One sample of every host pin, moved through the chain together
	typedef struct packed {
		logic		n_ce;
		logic		n_trd;
		logic		n_twr;
		logic [1:0]	ta;
		logic [7:0]	td;
	} pin_sample_t;

	localparam pin_sample_t PINS_IDLE = '{
		n_ce:	1'b1,
		n_trd:	1'b1,
		n_twr:	1'b1,
		ta:		2'd0,
		td:		8'd0
	};

	pin_sample_t	pins_raw;
	pin_sample_t	sync_q [SYNC_STAGES];
	pin_sample_t	pins_s;					// Synchronized view
	logic			access_on;
	logic			strobes_idle;
	logic			in_access;				// Command already sent for this access

	assign pins_raw = '{n_ce: n_ce, n_trd: n_trd, n_twr: n_twr, ta: ta, td: td_in};
	assign pins_s   = sync_q[SYNC_STAGES-1];

	// ----------------------------------------------------------
	// Synchronizer chain
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= PINS_IDLE;		// Strobes look released
			end
		end else begin
			sync_q[0] <= pins_raw;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Chip enable plus either strobe starts an access
	assign access_on    = !pins_s.n_ce && (!pins_s.n_trd || !pins_s.n_twr);
	assign strobes_idle = pins_s.n_trd && pins_s.n_twr;

	// ----------------------------------------------------------
	// Command generation
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			in_access <= 1'b0;
			bus_cmd   <= '0;
		end else begin
			if (access_on) begin
				in_access <= 1'b1;
			end else if (strobes_idle) begin
				in_access <= 1'b0;				// Rearm once both strobes are high
			end
			bus_cmd.valid    <= access_on && !in_access;	// Rising edge only
			bus_cmd.is_write <= !pins_s.n_twr;
			bus_cmd.port     <= pins_s.ta;
			bus_cmd.wdata    <= pins_s.td;		// Write data at the strobe
		end
	end

	// Read turnaround, top level builds the tristate from these
	assign tdir   = !pins_s.n_ce && !pins_s.n_trd;
	assign td_out = read_data;

endmodule

/* design/vdp_port/vdp_port_decoder.sv */
// ----------------------------------------------------------
// VDP style port logic: address pointer, two byte control
// sequence, R0-R7 and the VRAM read-ahead buffer
// ----------------------------------------------------------
`timescale 1ns/1ps

module vdp_port_decoder #(
	parameter int VRAM_ADDR_W = 14
) (
	input  logic				clk,
	input  logic				w_n_reset,
	input  cart_pkg::bus_cmd_t	bus_cmd,
	output logic [7:0]			read_data,		// Byte returned to the host
	// VRAM req/ack
	output logic				vram_req_valid,
	output cart_pkg::vram_req_t	vram_req,
	input  logic				vram_ack,
	input  cart_pkg::vram_rsp_t	vram_rsp,
	output logic [7:0][7:0]		regs			// Control registers R0-R7
);

	logic [VRAM_ADDR_W-1:0]	ptr;			// Auto-increment address pointer
	logic [VRAM_ADDR_W-1:0]	set_ptr;		// Address from a byte pair
	logic [VRAM_ADDR_W-1:0]	mem_addr;
	logic					latch_full;		// First byte held
	logic [7:0]				latch_val;
	logic [2:0]				last_idx;		// Most recently written register
	logic [7:0]				prefetch_buf;
	logic					cmd_p0;
	logic					cmd_p1;
	logic					pair_done;		// Second byte of a port 1 pair
	logic					mem_issue;
	logic					mem_write;
	logic					mem_go;

	// ----------------------------------------------------------
	// Command decode
	// ----------------------------------------------------------
	assign cmd_p0    = bus_cmd.valid && (bus_cmd.port == cart_pkg::PORT_VRAM_DATA);
	assign cmd_p1    = bus_cmd.valid && (bus_cmd.port == cart_pkg::PORT_VDP_CTRL);
	assign pair_done = cmd_p1 && bus_cmd.is_write && latch_full;
	assign set_ptr   = VRAM_ADDR_W'({bus_cmd.wdata[5:0], latch_val});

	always_comb begin
		// Port 0 always needs VRAM, port 1 only for address set with read
		mem_issue = cmd_p0 || (pair_done && !bus_cmd.wdata[7] && !bus_cmd.wdata[6]);
		mem_write = cmd_p0 && bus_cmd.is_write;
		mem_addr  = cmd_p0 ? ptr : set_ptr;
	end

	assign mem_go = mem_issue && !vram_req_valid;	// Dropped while a request is open

	// ----------------------------------------------------------
	// Control state
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ptr            <= '0;
			latch_full     <= 1'b0;
			last_idx       <= 3'd0;
			regs           <= '0;
			read_data      <= 8'd0;
			vram_req_valid <= 1'b0;
		end else begin
			if (vram_ack) begin
				vram_req_valid <= 1'b0;			// Request done at ack
			end
			if (mem_go) begin
				vram_req_valid <= 1'b1;
				ptr            <= mem_addr + 1'b1;	// Wraps at memory size
			end
			if (cmd_p0 && !bus_cmd.is_write && mem_go) begin
				read_data <= prefetch_buf;		// Hand out read-ahead byte
			end
			if (cmd_p1) begin
				if (!bus_cmd.is_write) begin
					read_data  <= regs[last_idx];
					latch_full <= 1'b0;			// Status read resets the pair
				end else if (!latch_full) begin
					latch_full <= 1'b1;
				end else if (bus_cmd.wdata[7]) begin
					regs[bus_cmd.wdata[2:0]] <= latch_val;
					last_idx   <= bus_cmd.wdata[2:0];
					latch_full <= 1'b0;
				end else if (bus_cmd.wdata[6]) begin
					ptr        <= set_ptr;		// Write mode, no read-ahead
					latch_full <= 1'b0;
				end else if (mem_go) begin
					latch_full <= 1'b0;			// Read mode, prefetch issued
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Payload registers
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mem_go) begin
			vram_req <= '{
				is_write:	mem_write,
				address:	cart_pkg::vram_addr_t'(mem_addr),
				wdata:		bus_cmd.wdata
			};
		end
		if (cmd_p1 && bus_cmd.is_write && !latch_full) begin
			latch_val <= bus_cmd.wdata;			// First byte of the pair
		end
		if (vram_rsp.valid) begin
			prefetch_buf <= vram_rsp.rdata;
		end
	end

endmodule

/* design/vram/vram_access.sv */
// ----------------------------------------------------------
// On-chip video memory behind a req/ack port
// Writes land at the ack, reads return two cycles later
// ----------------------------------------------------------
`timescale 1ns/1ps

module vram_access #(
	parameter int VRAM_ADDR_W = 14
) (
	input  logic				clk,
	input  logic				w_n_reset,
	input  logic				vram_req_valid,
	input  cart_pkg::vram_req_t	vram_req,
	output logic				vram_ack,
	output cart_pkg::vram_rsp_t	vram_rsp
);

	localparam int DEPTH = 1 << VRAM_ADDR_W;

	logic [7:0]				mem [DEPTH];
	logic [VRAM_ADDR_W-1:0]	req_addr;		// Address of the current request
	logic					take;			// Request accepted this cycle
	// Read path
	logic					rd_take_q;		// Request register holds a read
	logic [VRAM_ADDR_W-1:0]	req_addr_q;
	logic					rd_stage_v;
	logic [VRAM_ADDR_W-1:0]	rd_addr_q;		// Registered read address
	logic					rsp_valid_q;
	logic [7:0]				rsp_data_q;

	assign req_addr = vram_req.address[VRAM_ADDR_W-1:0];

	// Idle when not acking, so one pulse per request
	assign take = vram_req_valid && !vram_ack;

	// ----------------------------------------------------------
	// Handshake and valid pipeline
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			vram_ack    <= 1'b0;
			rd_take_q   <= 1'b0;
			rd_stage_v  <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			vram_ack    <= take;
			rd_take_q   <= take && !vram_req.is_write;
			rd_stage_v  <= rd_take_q;
			rsp_valid_q <= rd_stage_v;		// Two cycles after ack
		end
	end

	// ----------------------------------------------------------
	// Request register and read data path
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (take) begin
			req_addr_q <= req_addr;
		end
		if (rd_take_q) begin
			rd_addr_q <= req_addr_q;		// Stage 1
		end
		if (rd_stage_v) begin
			rsp_data_q <= mem[rd_addr_q];	// Stage 2
		end
	end

	// Store completes together with the ack
	always_ff @(posedge clk) begin
		if (take && vram_req.is_write) begin
			mem[req_addr] <= vram_req.wdata;
		end
	end

	assign vram_rsp = '{valid: rsp_valid_q, rdata: rsp_data_q};

endmodule

/* design/cart_top.sv */
// ----------------------------------------------------------
// MSX cartridge top: bus sync, VDP port decoder and VRAM
// chained, with the host data bus as a tristate
// ----------------------------------------------------------
`timescale 1ns/1ps

module cart_top #(
	parameter int VRAM_ADDR_W = cart_pkg::VRAM_ADDR_W_DEF,
	parameter int SYNC_STAGES = 2
) (
	input  logic			clk,
	input  logic			w_n_reset,
	// MSX cartridge connector
	input  logic			n_ce,
	input  logic			n_trd,
	input  logic			n_twr,
	input  logic [1:0]		ta,
	inout  wire  [7:0]		td,
	output logic			tdir,
	// Register contents for observation
	output logic [7:0][7:0]	regs
);

	logic [7:0]				td_in;
	logic [7:0]				td_out;
	logic [7:0]				read_data;
	cart_pkg::bus_cmd_t		bus_cmd;
	logic					vram_req_valid;
	cart_pkg::vram_req_t	vram_req;
	logic					vram_ack;
	cart_pkg::vram_rsp_t	vram_rsp;

	// ----------------------------------------------------------
	// Host data bus
	// ----------------------------------------------------------
	assign td    = tdir ? td_out : 8'hzz;	// Drive only during reads
	assign td_in = td;

	msx_bus_sync #(
		.SYNC_STAGES	(SYNC_STAGES)
	) u_msxbus (
		.clk			(clk),
		.w_n_reset		(w_n_reset),
		.n_ce			(n_ce),
		.n_trd			(n_trd),
		.n_twr			(n_twr),
		.ta				(ta),
		.td_in			(td_in),
		.td_out			(td_out),
		.tdir			(tdir),
		.read_data		(read_data),
		.bus_cmd		(bus_cmd)
	);

	vdp_port_decoder #(
		.VRAM_ADDR_W	(VRAM_ADDR_W)
	) u_vdp_port (
		.clk			(clk),
		.w_n_reset		(w_n_reset),
		.bus_cmd		(bus_cmd),
		.read_data		(read_data),
		.vram_req_valid	(vram_req_valid),
		.vram_req		(vram_req),
		.vram_ack		(vram_ack),
		.vram_rsp		(vram_rsp),
		.regs			(regs)
	);

	vram_access #(
		.VRAM_ADDR_W	(VRAM_ADDR_W)
	) u_vram (
		.clk			(clk),
		.w_n_reset		(w_n_reset),
		.vram_req_valid	(vram_req_valid),
		.vram_req		(vram_req),
		.vram_ack		(vram_ack),
		.vram_rsp		(vram_rsp)
	);

endmodule

/* verification/tb_msx_host.svh */
// ----------------------------------------------------------
// MSX host I/O cycles, LFSR stimulus and bounded waits
// Included inside the testbench module body
// ----------------------------------------------------------
`ifndef TB_MSX_HOST_SVH
`define TB_MSX_HOST_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit, LSB of the state is the bit taken
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

// Hands the message to the watchdog process
task automatic raise_timeout(input string msg);
	hang_msg = msg;
	hang     = 1'b1;
	#1;							// Watchdog ends the run in this step
endtask

// ----------------------------------------------------------
// OUT cycle, strobe held HOLD_CYCLES then bus idle
// ----------------------------------------------------------
task automatic port_write(input logic [1:0] port, input logic [7:0] data);
	void'(model_access(1'b1, port, data));
	@(posedge clk);
	#1;
	ta        = port;
	td_drv    = data;
	td_drv_en = 1'b1;			// Host owns td
	n_ce      = 1'b0;
	n_twr     = 1'b0;
	repeat (HOLD_CYCLES) @(posedge clk);
	#1;
	n_ce      = 1'b1;
	n_twr     = 1'b1;
	td_drv_en = 1'b0;
	repeat (IDLE_CYCLES) @(posedge clk);	// Room for the VRAM access
endtask

// IN cycle, td taken in the last strobe cycle and queued
task automatic port_read(input logic [1:0] port, input string what);
	logic [7:0]	exp;
	int			n;
	exp = model_access(1'b0, port, 8'h00);
	@(posedge clk);
	#1;
	ta    = port;
	n_ce  = 1'b0;
	n_trd = 1'b0;
	n     = 0;
	// Turnaround must come within the strobe
	while (!tdir && n < HOLD_CYCLES - 1) begin
		@(posedge clk);
		#1;
		n++;
	end
	if (!tdir) begin
		raise_timeout($sformatf("cartridge never drove td during %s", what));
	end
	repeat (HOLD_CYCLES - 1 - n) @(posedge clk);
	#1;
	got_q.push_back(td);
	exp_q.push_back(exp);
	what_q.push_back(what);
	@(posedge clk);
	#1;
	n_ce  = 1'b1;
	n_trd = 1'b1;
	repeat (IDLE_CYCLES) @(posedge clk);
endtask

// Drain of the compare queues, bounded
task automatic wait_checks_done();
	int n;
	n = 0;
	while ((got_q.size() != 0 || regs_ack != regs_req) && n < CHECK_WAIT) begin
		@(posedge clk);
		n++;
	end
	if (got_q.size() != 0 || regs_ack != regs_req) begin
		raise_timeout("compare process left checks pending");
	end
endtask

`endif

/* verification/tb_cart_top.sv */
// ----------------------------------------------------------
// Testbench for the MSX cartridge VDP port
// Drives host cycles and checks reads and regs against a model
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_cart_top;

	localparam int ADDR_W      = 14;
	localparam int SYNC_STAGES = 2;
	localparam int HOLD_CYCLES = 8;		// Strobe width in clocks
	localparam int IDLE_CYCLES = 12;	// Gap after each access
	localparam int CHECK_WAIT  = 50;
	localparam logic [ADDR_W-1:0] TOP_ADDR = '1;

	logic				clk = 1'b0;
	logic				w_n_reset;
	logic				n_ce;
	logic				n_trd;
	logic				n_twr;
	logic [1:0]			ta;
	logic [7:0]			td_drv;
	logic				td_drv_en;
	wire  [7:0]			td;
	logic				tdir;
	logic [7:0][7:0]	regs;

	// ----------------------------------------------------------
	// Reference model state
	// ----------------------------------------------------------
	logic [7:0]			m_mem [1 << ADDR_W];
	logic [ADDR_W-1:0]	m_ptr;
	logic				m_latch_full;
	logic [7:0]			m_latch_val;
	logic [7:0]			m_regs [8];
	logic [2:0]			m_last;			// Last written register
	logic [7:0]			m_prefetch;

	// Compare queues and bookkeeping
	logic [7:0]			got_q [$];
	logic [7:0]			exp_q [$];
	string				what_q [$];
	int					regs_req;
	int					regs_ack;
	logic [7:0]			cmp_got;
	logic [7:0]			cmp_exp;
	string				cmp_what;
	int					check_count;
	int					err_count;
	int					test_num;
	int					tests_failed;
	int					test_errs_start;
	logic [31:0]		lfsr_state;
	logic				hang = 1'b0;
	string				hang_msg;
	logic [ADDR_W-1:0]	addr_list [32];

	always #2 clk = ~clk;				// 4 ns clock

	assign td = td_drv_en ? td_drv : 8'hzz;

	cart_top #(
		.VRAM_ADDR_W	(ADDR_W),
		.SYNC_STAGES	(SYNC_STAGES)
	) i_dut (
		.clk		(clk),
		.w_n_reset	(w_n_reset),
		.n_ce		(n_ce),
		.n_trd		(n_trd),
		.n_twr		(n_twr),
		.ta			(ta),
		.td			(td),
		.tdir		(tdir),
		.regs		(regs)
	);

	// Applies one host access to the model and returns the byte a read sees
	function automatic logic [7:0] model_access(input logic is_write, input logic [1:0] port,
			input logic [7:0] wdata);
		logic [7:0] rd;
		rd = 8'h00;
		if (port == cart_pkg::PORT_VRAM_DATA) begin
			if (is_write) begin
				m_mem[m_ptr] = wdata;
			end else begin
				rd         = m_prefetch;	// Read-ahead byte
				m_prefetch = m_mem[m_ptr];
			end
			m_ptr = m_ptr + 1'b1;			// Wraps at memory size
		end else if (port == cart_pkg::PORT_VDP_CTRL) begin
			if (!is_write) begin
				rd           = m_regs[m_last];
				m_latch_full = 1'b0;
			end else if (!m_latch_full) begin
				m_latch_val  = wdata;
				m_latch_full = 1'b1;
			end else begin
				m_latch_full = 1'b0;
				if (wdata[7]) begin
					m_regs[wdata[2:0]] = m_latch_val;
					m_last             = wdata[2:0];
				end else begin
					m_ptr = ADDR_W'({wdata[5:0], m_latch_val});
					if (!wdata[6]) begin
						m_prefetch = m_mem[m_ptr];	// Read setup prefetches
						m_ptr      = m_ptr + 1'b1;
					end
				end
			end
		end
		return rd;
	endfunction

	`include "tb_msx_host.svh"

	task automatic set_write_addr(input logic [ADDR_W-1:0] a);
		port_write(cart_pkg::PORT_VDP_CTRL, a[7:0]);
		port_write(cart_pkg::PORT_VDP_CTRL, {2'b01, 6'(a >> 8)});
	endtask

	task automatic set_read_addr(input logic [ADDR_W-1:0] a);
		port_write(cart_pkg::PORT_VDP_CTRL, a[7:0]);
		port_write(cart_pkg::PORT_VDP_CTRL, {2'b00, 6'(a >> 8)});
	endtask

	task automatic check_regs();
		regs_req++;						// Compare process picks it up
	endtask

	task automatic end_test(input string name);
		int errs;
		wait_checks_done();
		errs = err_count - test_errs_start;
		if (errs == 0) begin
			$display("[test %0d] %s: ok", test_num, name);
		end else begin
			$display("[test %0d] %s: %0d error(s)", test_num, name, errs);
			tests_failed++;
		end
		test_num++;
		test_errs_start = err_count;
	endtask

	// ----------------------------------------------------------
	// Compare process on the falling edge
	// ----------------------------------------------------------
	always @(negedge clk) begin
		if (got_q.size() != 0) begin
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_what = what_q.pop_front();
			check_count++;
			assert (cmp_got == cmp_exp) else begin
				$display("FAILED at %0t: %s gave %02h, expected %02h",
					$time, cmp_what, cmp_got, cmp_exp);
				err_count++;
			end
		end
		if (regs_ack != regs_req) begin
			for (int i = 0; i < 8; i++) begin
				check_count++;
				assert (regs[i] == m_regs[i]) else begin
					$display("FAILED at %0t: R%0d is %02h, expected %02h",
						$time, i, regs[i], m_regs[i]);
					err_count++;
				end
			end
			regs_ack = regs_req;
		end
	end

	// Watchdog for the bounded waits
	always @(posedge hang) begin
		$display("Timeout: %s", hang_msg);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		w_n_reset       = 1'b0;
		n_ce            = 1'b1;			// Bus released
		n_trd           = 1'b1;
		n_twr           = 1'b1;
		ta              = 2'd0;
		td_drv          = 8'h00;
		td_drv_en       = 1'b0;
		lfsr_state      = 32'd96989;
		m_ptr           = '0;
		m_latch_full    = 1'b0;
		m_latch_val     = 8'h00;
		m_last          = 3'd0;
		m_prefetch      = 8'h00;
		test_num        = 1;
		tests_failed    = 0;
		test_errs_start = 0;
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = 8'h00;
		end
		repeat (10) @(posedge clk);
		#1;
		w_n_reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;

		// Idle bus, empty registers
		got_q.push_back({7'd0, tdir});
		exp_q.push_back(8'h00);
		what_q.push_back("tdir after reset");
		check_regs();
		end_test("reset state");

		port_write(cart_pkg::PORT_VDP_CTRL, 8'hA5);
		port_write(cart_pkg::PORT_VDP_CTRL, 8'h83);	// R3
		check_regs();
		port_read(cart_pkg::PORT_VDP_CTRL, "port 1 read of R3");
		end_test("register write and read back");

		// Burst through auto-increment and read-ahead
		addr_list[0] = ADDR_W'(take_bits(ADDR_W));
		set_write_addr(addr_list[0]);
		for (int i = 0; i < 8; i++) begin
			port_write(cart_pkg::PORT_VRAM_DATA, 8'(take_bits(8)));
		end
		set_read_addr(addr_list[0]);
		for (int i = 0; i < 8; i++) begin
			port_read(cart_pkg::PORT_VRAM_DATA, $sformatf("burst read %0d", i));
		end
		end_test("auto-increment burst");

		for (int i = 0; i < 32; i++) begin
			addr_list[i] = ADDR_W'(take_bits(ADDR_W));
			set_write_addr(addr_list[i]);
			port_write(cart_pkg::PORT_VRAM_DATA, 8'(take_bits(8)));
		end
		for (int i = 0; i < 32; i++) begin
			set_read_addr(addr_list[i]);
			port_read(cart_pkg::PORT_VRAM_DATA, $sformatf("readback at %h", addr_list[i]));
		end
		// Pointer steps from the top byte to zero
		set_write_addr(TOP_ADDR);
		port_write(cart_pkg::PORT_VRAM_DATA, 8'(take_bits(8)));
		port_write(cart_pkg::PORT_VRAM_DATA, 8'(take_bits(8)));
		set_read_addr(TOP_ADDR);
		port_read(cart_pkg::PORT_VRAM_DATA, "read at top address");
		port_read(cart_pkg::PORT_VRAM_DATA, "read after wrap");
		end_test("random access and wrap");

		port_write(cart_pkg::PORT_VDP_CTRL, 8'h3C);		// Stray first byte
		port_read(cart_pkg::PORT_VDP_CTRL, "port 1 read after lone byte");
		port_write(cart_pkg::PORT_VDP_CTRL, 8'h5A);
		port_write(cart_pkg::PORT_VDP_CTRL, 8'h86);		// R6
		check_regs();
		port_read(cart_pkg::PORT_VDP_CTRL, "port 1 read of R6");
		end_test("latch cleared by port 1 read");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			test_num - 1, tests_failed, check_count, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* cart_top.f */
+incdir+verification
common/cart_pkg.sv
design/msxbus/msx_bus_sync.sv
design/vdp_port/vdp_port_decoder.sv
design/vram/vram_access.sv
design/cart_top.sv
verification/tb_cart_top.sv

/* Makefile */
# Verilator build and run for the MSX cartridge testbench

TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_cart_top
FLIST = cart_top.f
LOG   = sim.log

.PHONY: sim clean

# Pass or fail is taken from the log, not the exit code of the binary
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
